// File: Makefile
TOP = tb_rect_fill

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rect_fill_top.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f rect_fill_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: hdl/display_timing.sv
// display_timing: raster counters with sync, data enable and frame pulse,
// one pixel per clock, all outputs registered and aligned to sx/sy
`timescale 1ns/10ps

module display_timing #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 80,
    parameter int HS_START = 66,
    parameter int HS_END   = 71,
    parameter int V_ACTIVE = 36,
    parameter int V_TOTAL  = 40,
    parameter int VS_START = 37,
    parameter int VS_END   = 38
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    output rect_fill_pkg::coord_t sx,
    output rect_fill_pkg::coord_t sy,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output logic                  frame
);

    localparam rect_fill_pkg::coord_t H_LAST = rect_fill_pkg::coord_t'(H_TOTAL - 1);
    localparam rect_fill_pkg::coord_t V_LAST = rect_fill_pkg::coord_t'(V_TOTAL - 1);

    rect_fill_pkg::coord_t h_cnt;   // raw column count
    rect_fill_pkg::coord_t v_cnt;   // raw row count

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;                                // end of line
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 8'd1;
        end else begin
            h_cnt <= h_cnt + 8'd1;
        end
    end

    // decode one stage late so sync and de line up with sx/sy
    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= h_cnt;
            sy    <= v_cnt;
            hsync <= (h_cnt >= HS_START[7:0]) && (h_cnt <= HS_END[7:0]);   // inclusive
            vsync <= (v_cnt >= VS_START[7:0]) && (v_cnt <= VS_END[7:0]);
            de    <= (h_cnt < H_ACTIVE[7:0]) && (v_cnt < V_ACTIVE[7:0]);
            frame <= (h_cnt == '0) && (v_cnt == '0);    // top left pixel
        end
    end

endmodule

// File: hdl/fb_write_if.sv
// fb_write_if: pixel write channel from the drawing side into the framebuffer
`timescale 1ns/10ps

interface fb_write_if;

    logic                  we;      // write strobe, one pixel per cycle
    rect_fill_pkg::coord_t x;       // buffer column
    rect_fill_pkg::coord_t y;       // buffer row
    rect_fill_pkg::cidx_t  cidx;    // colour index to store
    logic                  busy;    // display is reading, hold off writes

    modport draw (
        output we, x, y, cidx,
        input  busy
    );

    modport mem (
        input  we, x, y, cidx,
        output busy
    );

endinterface

// File: hdl/framebuffer.sv
// framebuffer: colour index memory written in blanking, read at the scan
// position, palette lookup with syncs delayed to match the read
`timescale 1ns/10ps

module framebuffer #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 36
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    fb_write_if.mem               wr,
    input  rect_fill_pkg::coord_t sx,
    input  rect_fill_pkg::coord_t sy,
    input  logic                  de,
    input  logic                  hsync,
    input  logic                  vsync,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  de_out,
    output logic [3:0]            red,
    output logic [3:0]            green,
    output logic [3:0]            blue
);

    localparam int DEPTH  = H_ACTIVE * V_ACTIVE;
    localparam int ADDR_W = $clog2(DEPTH);

    rect_fill_pkg::cidx_t    mem [DEPTH];       // one index per pixel
    rect_fill_pkg::cidx_t    rd_cidx;
    rect_fill_pkg::rgb444_t  rgb;
    logic [ADDR_W-1:0]       wr_addr, rd_addr;

    assign wr_addr = ADDR_W'(wr.y) * ADDR_W'(H_ACTIVE) + ADDR_W'(wr.x);
    assign rd_addr = ADDR_W'(sy) * ADDR_W'(H_ACTIVE) + ADDR_W'(sx);

    // display reads own the active area
    assign wr.busy = de;

    always_ff @(posedge clk_100m) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.cidx;
        end
    end

    // read only inside active, address is out of range in blanking
    always_ff @(posedge clk_100m) begin
        if (de) begin
            rd_cidx <= mem[rd_addr];
        end
    end

    // one stage to match the memory read
    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de_out    <= 1'b0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            de_out    <= de;
        end
    end

    assign rgb   = rect_fill_pkg::palette[rd_cidx];
    assign red   = de_out ? rgb.red   : 4'h0;   // black in blanking
    assign green = de_out ? rgb.green : 4'h0;
    assign blue  = de_out ? rgb.blue  : 4'h0;

endmodule

// File: hdl/rect_fill_engine.sv
// rect_fill_engine: walks a filled rectangle row by row, one coordinate
// per cycle with oe high, corners inclusive
`timescale 1ns/10ps

module rect_fill_engine (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  oe,
    input  rect_fill_pkg::coord_t x0,
    input  rect_fill_pkg::coord_t y0,
    input  rect_fill_pkg::coord_t x1,
    input  rect_fill_pkg::coord_t y1,
    fb_write_if.draw              wr,
    output logic                  drawing,
    output logic                  done
);

    rect_fill_pkg::fill_state_t state;
    rect_fill_pkg::coord_t      x0_r, y0_r;    // latched top left
    rect_fill_pkg::coord_t      x1_r, y1_r;    // latched bottom right
    rect_fill_pkg::coord_t      x_pos, y_pos;  // current pixel

    // corner latch, payload only
    always_ff @(posedge clk_100m) begin
        if (start && state == rect_fill_pkg::F_IDLE) begin
            x0_r <= x0;
            y0_r <= y0;
            x1_r <= x1;
            y1_r <= y1;
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state <= rect_fill_pkg::F_IDLE;
            x_pos <= '0;
            y_pos <= '0;
        end else begin
            case (state)
                rect_fill_pkg::F_INIT: begin
                    x_pos <= x0_r;                  // first pixel next cycle
                    y_pos <= y0_r;
                    state <= rect_fill_pkg::F_FILL;
                end
                rect_fill_pkg::F_FILL: begin
                    if (oe) begin                   // hold position while stalled
                        if (x_pos == x1_r) begin
                            if (y_pos == y1_r) begin
                                state <= rect_fill_pkg::F_DONE;
                            end else begin
                                x_pos <= x0_r;      // wrap to next row
                                y_pos <= y_pos + 8'd1;
                            end
                        end else begin
                            x_pos <= x_pos + 8'd1;
                        end
                    end
                end
                rect_fill_pkg::F_DONE: state <= rect_fill_pkg::F_IDLE;
                default: if (start) state <= rect_fill_pkg::F_INIT;
            endcase
        end
    end

    assign wr.x    = x_pos;
    assign wr.y    = y_pos;
    assign drawing = (state == rect_fill_pkg::F_FILL) && oe;   // valid coord this cycle
    assign done    = (state == rect_fill_pkg::F_DONE);         // one cycle after last

endmodule

// File: hdl/rect_fill_pkg.sv
// rect_fill_pkg: shared types, fixed 16 colour palette and rectangle geometry
// for the filled rectangle drawing subsystem
package rect_fill_pkg;

    typedef logic [7:0] coord_t;    // screen or buffer coordinate
    typedef logic [3:0] cidx_t;     // colour index

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // index 0 stays black, rest are distinct
    localparam rgb444_t palette [16] = '{
        12'h000, 12'h125, 12'h725, 12'h085,
        12'ha53, 12'h555, 12'hccc, 12'hfff,
        12'hf04, 12'hfa0, 12'hfe2, 12'h0e3,
        12'h2af, 12'h879, 12'hf7a, 12'hfca
    };

    typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_INIT, S_DRAW, S_DONE} seq_state_t;
    typedef enum logic [1:0] {F_IDLE, F_INIT, F_FILL, F_DONE} fill_state_t;

    // shape i starts at base + step * i
    localparam coord_t RECT_X0_BASE = 8'd4;
    localparam coord_t RECT_Y0_BASE = 8'd4;
    localparam coord_t RECT_STEP    = 8'd3;
    localparam coord_t RECT_W       = 8'd24;
    localparam coord_t RECT_H       = 8'd14;

endpackage

// File: hdl/rect_fill_top.sv
// rect_fill_top: filled rectangle drawing subsystem, timing, framebuffer,
// sequencer and fill engine on one clock
`timescale 1ns/10ps

module rect_fill_top #(
    parameter int H_ACTIVE  = 64,
    parameter int H_TOTAL   = 80,
    parameter int HS_START  = 66,
    parameter int HS_END    = 71,
    parameter int V_ACTIVE  = 36,
    parameter int V_TOTAL   = 40,
    parameter int VS_START  = 37,
    parameter int VS_END    = 38,
    parameter int SHAPE_CNT = 6,
    parameter int PIX_FRAME = 800
) (
    input  logic       clk_100m,
    input  logic       arst_n,
    input  logic       start,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic       draw_done
);

    rect_fill_pkg::coord_t sx, sy;              // scan position
    rect_fill_pkg::coord_t x0, y0, x1, y1;      // rectangle corners
    logic tim_hsync, tim_vsync, tim_de, frame;
    logic rect_start, rect_done, oe, drawing;

    fb_write_if fb_bus ();

    assign fb_bus.we = drawing;                 // every valid coord is a write

    display_timing #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .HS_START(HS_START), .HS_END(HS_END),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .VS_START(VS_START), .VS_END(VS_END)
    ) u_timing (
        .clk_100m, .arst_n, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de), .frame
    );

    framebuffer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_fb (
        .clk_100m, .arst_n, .wr(fb_bus.mem), .sx, .sy,
        .de(tim_de), .hsync(tim_hsync), .vsync(tim_vsync),
        .hsync_out(hsync), .vsync_out(vsync), .de_out(de), .red, .green, .blue
    );

    shape_sequencer #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .SHAPE_CNT(SHAPE_CNT), .PIX_FRAME(PIX_FRAME)
    ) u_seq (
        .clk_100m, .arst_n, .start, .frame, .busy(fb_bus.busy), .wr(fb_bus.draw),
        .rect_start, .oe, .x0, .y0, .x1, .y1, .rect_done, .draw_done
    );

    rect_fill_engine u_engine (
        .clk_100m, .arst_n, .start(rect_start), .oe, .x0, .y0, .x1, .y1,
        .wr(fb_bus.draw), .drawing, .done(rect_done)
    );

endmodule

// File: hdl/shape_sequencer.sv
// shape_sequencer: clears the buffer, then issues SHAPE_CNT overlapping
// rectangles, pacing writes to PIX_FRAME pixels per frame
`timescale 1ns/10ps

module shape_sequencer #(
    parameter int H_ACTIVE  = 64,
    parameter int V_ACTIVE  = 36,
    parameter int SHAPE_CNT = 6,
    parameter int PIX_FRAME = 800
) (
    input  logic                  clk_100m,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  frame,
    input  logic                  busy,
    fb_write_if.draw              wr,
    output logic                  rect_start,
    output logic                  oe,
    output rect_fill_pkg::coord_t x0,
    output rect_fill_pkg::coord_t y0,
    output rect_fill_pkg::coord_t x1,
    output rect_fill_pkg::coord_t y1,
    input  logic                  rect_done,
    output logic                  draw_done
);

    localparam int SID_W = $clog2(SHAPE_CNT);
    localparam int CNT_W = $clog2(PIX_FRAME + 1);

    rect_fill_pkg::seq_state_t state;
    logic [SID_W-1:0]          shape_id;
    logic [CNT_W-1:0]          pix_cnt;         // pixels granted this frame
    rect_fill_pkg::coord_t     shape_x0, shape_y0;
    logic                      load_clear, load_shape, active;

    assign shape_x0   = rect_fill_pkg::RECT_X0_BASE + rect_fill_pkg::RECT_STEP * shape_id;
    assign shape_y0   = rect_fill_pkg::RECT_Y0_BASE + rect_fill_pkg::RECT_STEP * shape_id;
    assign load_clear = start && (state == rect_fill_pkg::S_IDLE
                               || state == rect_fill_pkg::S_DONE);  // busy starts ignored
    assign load_shape = (state == rect_fill_pkg::S_INIT);
    assign active     = (state == rect_fill_pkg::S_CLEAR) || (state == rect_fill_pkg::S_DRAW);

    // corners and colour ride along with rect_start
    always_ff @(posedge clk_100m) begin
        if (load_clear) begin
            x0      <= '0;                          // whole buffer in black
            y0      <= '0;
            x1      <= rect_fill_pkg::coord_t'(H_ACTIVE - 1);
            y1      <= rect_fill_pkg::coord_t'(V_ACTIVE - 1);
            wr.cidx <= '0;
        end else if (load_shape) begin
            x0      <= shape_x0;
            y0      <= shape_y0;
            x1      <= shape_x0 + rect_fill_pkg::RECT_W - 8'd1;
            y1      <= shape_y0 + rect_fill_pkg::RECT_H - 8'd1;
            wr.cidx <= rect_fill_pkg::cidx_t'(shape_id) + 4'd1;   // skip black
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state      <= rect_fill_pkg::S_IDLE;
            shape_id   <= '0;
            rect_start <= 1'b0;
        end else begin
            rect_start <= 1'b0;
            case (state)
                rect_fill_pkg::S_CLEAR: if (rect_done) state <= rect_fill_pkg::S_INIT;
                rect_fill_pkg::S_INIT: begin
                    rect_start <= 1'b1;
                    state      <= rect_fill_pkg::S_DRAW;
                end
                rect_fill_pkg::S_DRAW: begin
                    if (rect_done) begin
                        if (shape_id == SID_W'(SHAPE_CNT - 1)) begin
                            state <= rect_fill_pkg::S_DONE;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= rect_fill_pkg::S_INIT;
                        end
                    end
                end
                default: begin                      // idle or done, wait for start
                    if (load_clear) begin
                        rect_start <= 1'b1;
                        shape_id   <= '0;
                        state      <= rect_fill_pkg::S_CLEAR;
                    end
                end
            endcase
        end
    end

    // per-frame write budget
    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            pix_cnt <= '0;
        end else if (frame) begin
            pix_cnt <= '0;
        end else if (oe) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    assign oe        = active && !busy && (pix_cnt < CNT_W'(PIX_FRAME));
    assign draw_done = (state == rect_fill_pkg::S_DONE);    // held until next start

endmodule

// File: rect_fill_top.f
hdl/rect_fill_pkg.sv
hdl/fb_write_if.sv
hdl/display_timing.sv
hdl/rect_fill_engine.sv
hdl/shape_sequencer.sv
hdl/framebuffer.sv
hdl/rect_fill_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_rect_fill.sv

// File: verification/rect_fill_stimulus.txt
# start : pulse start, wait for draw_done, then check every pix line
# pix x y idx : scan column, scan row, expected colour index
start
start
pix 0 0 0
pix 4 4 1
pix 3 4 0
pix 4 3 0
pix 27 4 1
pix 28 4 0
pix 4 17 1
pix 4 18 0
pix 19 19 6
pix 18 19 5
pix 42 32 6
pix 43 32 0
pix 42 33 0
pix 16 29 5
pix 16 30 0
pix 15 29 0
pix 63 35 0

// File: verification/tb_checker.sv
// tb_checker: watches the DUT outputs, checks raster timing, blanking,
// write pacing and the colour at each sample point
`timescale 1ns/10ps

module tb_checker #(
    parameter int H_ACTIVE  = 64,
    parameter int H_TOTAL   = 80,
    parameter int V_ACTIVE  = 36,
    parameter int VS_START  = 37,
    parameter int VS_END    = 38,
    parameter int SHAPE_CNT = 6,
    parameter int PIX_FRAME = 800,
    parameter int MAX_SMP   = 32
) (
    input  logic       clk_100m,
    input  logic       arst_n,
    input  logic       start,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       de,
    input  logic [3:0] red,
    input  logic [3:0] green,
    input  logic [3:0] blue,
    input  logic       draw_done,
    input  logic       check_en,
    input  int         n_samples,
    input  int         smp_x [MAX_SMP],
    input  int         smp_y [MAX_SMP],
    input  int         smp_c [MAX_SMP],
    output logic       check_done,
    output int         value_errs,
    output int         other_errs
);

    // shape i sits at base + step * i, colour i + 1
    localparam int X0_BASE    = 4;
    localparam int Y0_BASE    = 4;
    localparam int STEP       = 3;
    localparam int RECT_W     = 24;
    localparam int RECT_H     = 14;
    localparam int FILL_PIX   = H_ACTIVE * V_ACTIVE + SHAPE_CNT * RECT_W * RECT_H;
    localparam int MIN_FRAMES = (FILL_PIX + PIX_FRAME - 1) / PIX_FRAME - 1;    // pulses between windows
    localparam int VS_GAP     = (H_TOTAL - H_ACTIVE) + (VS_START - V_ACTIVE) * H_TOTAL;
    localparam int VS_LEN     = (VS_END - VS_START + 1) * H_TOTAL;

    int   n_val = 0, n_oth = 0;
    int   cyc = 0, col = 0, row = 0, de_cnt = 0, hits = 0;
    int   frames = 0, frames_at_start = 0;
    int   last_hs = -1, last_de_fall = -1, vs_rise = 0;
    logic de_q = 1'b0, hs_q = 1'b0, vs_q = 1'b0, dd_q = 1'b0, start_q = 1'b0;
    logic vs_seen = 1'b1, de_cnt_ok = 1'b0, armed = 1'b0;   // first line after reset is row 0

    assign value_errs = n_val;
    assign other_errs = n_oth;

    function automatic int rule_index(input int x, input int y);
        int idx;
        idx = 0;
        for (int i = 0; i < SHAPE_CNT; i++) begin
            if (x >= X0_BASE + STEP * i && x < X0_BASE + STEP * i + RECT_W
                && y >= Y0_BASE + STEP * i && y < Y0_BASE + STEP * i + RECT_H) begin
                idx = i + 1;                    // later shape paints over
            end
        end
        return idx;
    endfunction

    task automatic check_chan(input string name, input logic [3:0] want, input logic [3:0] got);
        if (got !== want) begin
            $display("ERR %0t %s exp %h got %h at (%0d,%0d)", $time, name, want, got, col, row);
            n_val++;
        end
    endtask

    task automatic check_samples();
        rect_fill_pkg::rgb444_t want;
        for (int k = 0; k < n_samples; k++) begin
            if (smp_x[k] == col && smp_y[k] == row) begin
                hits++;
                want = rect_fill_pkg::palette[smp_c[k][3:0]];
                if (rule_index(col, row) != smp_c[k]) begin
                    $display("stimulus index %0d at (%0d,%0d) disagrees with the shape rule",
                             smp_c[k], col, row);
                    n_oth++;
                end
                check_chan("red", want.red, red);
                check_chan("green", want.green, green);
                check_chan("blue", want.blue, blue);
            end
        end
    endtask

    // outputs change on the rising edge, look at them on the falling one
    always @(negedge clk_100m) begin
        cyc++;
        if (!arst_n) begin
            check_done = 1'b0;
            if (draw_done || de || hsync || vsync) begin
                $display("outputs are not idle during reset at %0t", $time);
                n_oth++;
            end
        end else begin
            if (!de && {red, green, blue} != 12'h000) begin
                $display("ERR %0t rgb exp 000 got %h in blanking", $time, {red, green, blue});
                n_val++;
            end
            if (de && !de_q) begin              // new active line
                col = 0;
                row = vs_seen ? 0 : row + 1;
                if (vs_seen) begin              // new frame
                    if (de_cnt_ok && de_cnt != H_ACTIVE * V_ACTIVE) begin
                        $display("ERR %0t de count exp %0d got %0d", $time,
                                 H_ACTIVE * V_ACTIVE, de_cnt);
                        n_val++;
                    end
                    de_cnt    = 0;
                    de_cnt_ok = 1'b1;
                    frames++;
                    if (check_en && !check_done && !armed) begin
                        armed = 1'b1;           // sample this whole frame
                        hits  = 0;
                    end
                end
                vs_seen = 1'b0;
            end else if (de) begin
                col++;
            end
            if (de) begin
                de_cnt++;
                if (armed) check_samples();
            end
            if (!de && de_q) last_de_fall = cyc;
            if (hsync && !hs_q) begin
                if (last_hs >= 0 && cyc - last_hs != H_TOTAL) begin
                    $display("ERR %0t hsync period exp %0d got %0d", $time, H_TOTAL, cyc - last_hs);
                    n_val++;
                end
                last_hs = cyc;
            end
            if (vsync && !vs_q) begin
                if (last_de_fall >= 0 && cyc - last_de_fall != VS_GAP) begin
                    $display("ERR %0t vsync start exp %0d got %0d cycles after de", $time,
                             VS_GAP, cyc - last_de_fall);
                    n_val++;
                end
                vs_seen = 1'b1;
                vs_rise = cyc;
                if (armed) begin                // active area of the frame is over
                    armed      = 1'b0;
                    check_done = 1'b1;
                    if (hits != n_samples) begin
                        $display("only %0d of %0d sample points were seen", hits, n_samples);
                        n_oth++;
                    end
                end
            end
            if (!vsync && vs_q && cyc - vs_rise != VS_LEN) begin
                $display("ERR %0t vsync length exp %0d got %0d", $time, VS_LEN, cyc - vs_rise);
                n_val++;
            end
            if (start_q && draw_done) begin
                $display("draw_done stayed high after start at %0t", $time);
                n_oth++;
            end
            if (start) frames_at_start = frames;
            if (draw_done && !dd_q && frames - frames_at_start < MIN_FRAMES) begin
                $display("draw_done rose after %0d frames, the write budget needs at least %0d",
                         frames - frames_at_start, MIN_FRAMES);
                n_oth++;
            end
            if (!check_en) check_done = 1'b0;
        end
        de_q    = de;
        hs_q    = hsync;
        vs_q    = vsync;
        dd_q    = draw_done;
        start_q = start;
    end

endmodule

// File: verification/tb_clock_gen.sv
// tb_clock_gen: 100 MHz testbench clock and power-on reset
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_100m,
    output logic arst_n
);

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;    // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk_100m);     // four cycles in reset
        #1 arst_n = 1'b1;
    end

endmodule

// File: verification/tb_rect_fill.sv
// tb_rect_fill is the testbench top that reads the stimulus file,
// pulses start, feeds the sample points to the checker and bounds the run
`timescale 1ns/10ps

module tb_rect_fill;

    localparam int MAX_SMP     = 32;
    localparam int TIMEOUT_CYC = 20 * 80 * 40;  // 20 frames of 3200 cycles

    logic       clk_100m, arst_n, start;
    logic       hsync, vsync, de, draw_done;
    logic [3:0] red, green, blue;
    logic       check_en, check_done;
    int         value_errs, other_errs;
    int         smp_x [MAX_SMP];
    int         smp_y [MAX_SMP];
    int         smp_c [MAX_SMP];
    int         n_samples, n_starts;
    int         phase = 0;                      // 1 during drawing and 2 during checks
    int         cycles = 0;

    tb_clock_gen i_clock (.clk_100m, .arst_n);

    rect_fill_top i_rect_fill_top (
        .clk_100m, .arst_n, .start, .hsync, .vsync, .de,
        .red, .green, .blue, .draw_done
    );

    tb_checker #(.MAX_SMP(MAX_SMP)) i_checker (
        .clk_100m, .arst_n, .start, .hsync, .vsync, .de, .red, .green, .blue,
        .draw_done, .check_en, .n_samples, .smp_x, .smp_y, .smp_c,
        .check_done, .value_errs, .other_errs
    );

    // keeps start and pix lines and skips every other line
    function automatic bit load_stimulus();
        int              fd, x, y, c, code;
        logic [63:0]     tok;
        logic [8*96-1:0] rest;
        bit              ok;
        ok        = 1'b1;
        n_samples = 0;
        n_starts  = 0;
        fd = $fopen("verification/rect_fill_stimulus.txt", "r");
        if (fd == 0) return 1'b0;
        while (ok && $fscanf(fd, "%s", tok) == 1) begin
            if (tok == 64'("start")) begin
                n_starts++;
            end else if (tok == 64'("pix") && n_samples < MAX_SMP) begin
                code = $fscanf(fd, "%d %d %d", x, y, c);
                if (code == 3) begin
                    smp_x[n_samples] = x;
                    smp_y[n_samples] = y;
                    smp_c[n_samples] = c;
                    n_samples++;
                end else begin
                    ok = 1'b0;                  // pix line without three numbers
                end
            end else begin
                code = $fgets(rest, fd);        // skip rest of line
            end
        end
        $fclose(fd);
        return ok && n_starts > 0 && n_samples > 0;
    endfunction

    task automatic run_draws();
        while (!arst_n) @(posedge clk_100m);
        repeat (3) @(posedge clk_100m);
        for (int s = 0; s < n_starts; s++) begin
            @(posedge clk_100m);
            #1 start = 1'b1;                    // one cycle strobe
            @(posedge clk_100m);
            #1 start = 1'b0;
            phase = 1;
            while (!draw_done) @(negedge clk_100m);
            phase = 2;
            @(posedge clk_100m);
            #1 check_en = 1'b1;                 // checker takes the next full frame
            while (!check_done) @(posedge clk_100m);
            #1 check_en = 1'b0;
            phase = 0;
        end
    endtask

    task automatic finish_run();
        $display("checks complete: %0d value errors, %0d other errors",
                 value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        start    = 1'b0;
        check_en = 1'b0;
        if (!load_stimulus()) begin
            $display("no valid start and sample list in verification/rect_fill_stimulus.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            run_draws();
            finish_run();
        end
    end

    always @(posedge clk_100m) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYC) begin
            if (phase == 1) begin
                $display("timeout: draw_done never rose after start");
            end else begin
                $display("timeout: the sample checks never finished");
            end
            $display("** FAIL **");
            $finish;
        end
    end

endmodule
